//--- dv/icache_tb.sv
module icache_tb;
    import icache_pkg::*;

    localparam int index_w = index_w_default;
    localparam int timeout_cycles = 20;

    localparam logic [tag_w-1:0] first_tag = 23'h12345;
    localparam logic [tag_w-1:0] tag_a = 23'h00a11;
    localparam logic [tag_w-1:0] tag_b = 23'h00b22;
    localparam logic [tag_w-1:0] tag_c = 23'h00c33;
    localparam logic [index_w-1:0] shared_index = 6'd9;

    logic                clk = 1'b0;
    logic                rst;
    logic                valid;
    logic [tag_w-1:0]    tag;
    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;
    logic                addr_ok;
    logic                data_ok;
    logic [word_w-1:0]   rdata;
    logic                rd_req;
    logic [addr_w-1:0]   rd_addr;
    logic [line_w-1:0]   ret_data;
    logic [31:0]         lfsr;

    icache #(
        .INDEX_W(index_w)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .tag      (tag),
        .index    (index),
        .offset   (offset),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .ret_data (ret_data)
    );

    always #5 clk = ~clk;

    // memory model, each half is the address xor a rotated copy
    function automatic logic [line_w-1:0] model_line(input logic [addr_w-1:0] a);
        logic [31:0] lo;
        logic [31:0] hi;
        lo = a ^ {a[24:0], a[31:25]};
        hi = a ^ {a[18:0], a[31:19]};
        return {hi, lo};
    endfunction

    // answers in the strobe cycle
    assign ret_data = model_line(rd_addr);

    function automatic logic [word_w-1:0] expected_word(input logic [tag_w-1:0] t,
                                                        input logic [index_w-1:0] i,
                                                        input logic [offset_w-1:0] o);
        logic [line_w-1:0] line;
        line = model_line({t, i, offset_w'(0)});
        return o[2] ? line[63:32] : line[31:0];
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    task automatic stop_run;
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // called on a falling edge, returns on the one before the accepting edge
    task automatic wait_addr_ok;
        int waited;
        waited = 0;
        while (!addr_ok) begin
            @(negedge clk);
            waited++;
            if (waited > timeout_cycles) begin
                $display("timeout at time %0t: the cache never raised addr_ok", $time);
                stop_run();
            end
        end
    endtask

    // single request, latency counted from the accepting edge
    task automatic fetch_word(input logic [tag_w-1:0] t, input logic [index_w-1:0] i,
                              input logic [offset_w-1:0] o, output int latency);
        logic [addr_w-1:0] line_addr;
        logic              refilled;
        line_addr = {t, i, offset_w'(0)};
        refilled = 1'b0;
        @(negedge clk);
        valid = 1'b1;
        tag = t;
        index = i;
        offset = o;
        wait_addr_ok();
        @(negedge clk);
        valid = 1'b0;
        latency = 1;
        while (!data_ok) begin
            if (rd_req) begin
                check_value(64'(rd_addr), 64'(line_addr), "refill address");
                refilled = 1'b1;
            end
            @(negedge clk);
            latency++;
            if (latency > timeout_cycles) begin
                $display("timeout at time %0t: no data_ok for an accepted request", $time);
                stop_run();
            end
        end
        check_value(64'(rdata), 64'(expected_word(t, i, o)), "returned word");
        check_value(64'(latency == 1 || latency == 3), 64'(1), "latency of one or three");
        check_value(64'(refilled), 64'(latency == 3), "refill strobe only on a miss");
    endtask

    task automatic cold_miss;
        int lat;
        fetch_word(first_tag, 6'd5, 3'd4, lat);
        check_value(64'(lat), 64'(3), "cold miss latency");
    endtask

    task automatic hit_latency_words;
        int lat;
        fetch_word(first_tag, 6'd5, 3'd0, lat);
        check_value(64'(lat), 64'(1), "hit latency, low word");
        fetch_word(first_tag, 6'd5, 3'd4, lat);
        check_value(64'(lat), 64'(1), "hit latency, high word");
    endtask

    task automatic two_way_fill;
        int lat;
        fetch_word(tag_a, shared_index, 3'd0, lat);
        check_value(64'(lat), 64'(3), "first fill of the set");
        fetch_word(tag_b, shared_index, 3'd4, lat);
        check_value(64'(lat), 64'(3), "second fill of the set");
        fetch_word(tag_a, shared_index, 3'd4, lat);
        check_value(64'(lat), 64'(1), "first tag still resident");
        fetch_word(tag_b, shared_index, 3'd0, lat);
        check_value(64'(lat), 64'(1), "second tag in the other way");
    endtask

    task automatic eviction;
        int                lat;
        logic [31:0]       r;
        logic [tag_w-1:0]  t;
        fetch_word(tag_c, shared_index, 3'd4, lat);
        check_value(64'(lat), 64'(3), "third tag misses");
        fetch_word(tag_c, shared_index, 3'd0, lat);
        check_value(64'(lat), 64'(1), "third tag hits after fill");
        // a hit on tag a means tag b was the victim
        fetch_word(tag_a, shared_index, 3'd0, lat);
        if (lat == 1) begin
            fetch_word(tag_b, shared_index, 3'd0, lat);
            check_value(64'(lat), 64'(3), "one of the first two tags evicted");
        end
        for (int k = 0; k < 12; k++) begin
            random_bits(2, r);
            t = (r % 3 == 0) ? tag_a : ((r % 3 == 1) ? tag_b : tag_c);
            random_bits(1, r);
            fetch_word(t, shared_index, {r[0], 2'b00}, lat);
        end
    endtask

    task automatic pipelined_hits;
        logic [tag_w-1:0]  t;
        logic [word_w-1:0] exp_q [$];
        int                lat;
        t = 23'h7f0f0;
        for (int k = 0; k < 4; k++) begin
            fetch_word(t, index_w'(20 + k), 3'd0, lat);
        end
        @(negedge clk);
        valid = 1'b1;
        tag = t;
        index = index_w'(20);
        offset = 3'd0;
        exp_q.push_back(expected_word(t, index, offset));
        wait_addr_ok();
        // predecessor returns while the next one is accepted
        for (int k = 1; k < 8; k++) begin
            @(negedge clk);
            check_value(64'(data_ok), 64'(1), "pipelined data_ok");
            check_value(64'(rdata), 64'(exp_q.pop_front()), "pipelined word");
            check_value(64'(addr_ok), 64'(1), "pipelined request accepted");
            index = index_w'(20 + k % 4);
            offset = k[0] ? 3'd4 : 3'd0;
            exp_q.push_back(expected_word(t, index, offset));
        end
        @(negedge clk);
        valid = 1'b0;
        check_value(64'(data_ok), 64'(1), "last pipelined data_ok");
        check_value(64'(rdata), 64'(exp_q.pop_front()), "last pipelined word");
    endtask

    task automatic random_traffic;
        logic [31:0]         r;
        logic [tag_w-1:0]    t;
        logic [index_w-1:0]  i;
        logic [offset_w-1:0] o;
        int                  lat;
        int                  hits;
        hits = 0;
        for (int k = 0; k < 40; k++) begin
            random_bits(2, r);
            t = 23'h2a000 + tag_w'(r);
            random_bits(3, r);
            i = index_w'(32 + r);
            random_bits(3, r);
            o = offset_w'(r);
            random_bits(2, r);
            repeat (r[1:0]) @(negedge clk);
            fetch_word(t, i, o, lat);
            if (lat == 1) begin
                hits++;
            end
        end
        check_value(64'(hits > 0), 64'(1), "random traffic saw hits");
    endtask

    initial begin
        rst = 1'b1;
        valid = 1'b0;
        tag = '0;
        index = '0;
        offset = '0;
        lfsr = 32'h7887;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cold_miss();
        hit_latency_words();
        two_way_fill();
        eviction();
        pipelined_hits();
        random_traffic();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- flist.f
source/icache_pkg.sv
source/icache_data_ram.sv
source/icache_tag_store.sv
source/icache_way_select.sv
source/icache_ctrl.sv
source/icache.sv
dv/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/icache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1

//--- source/icache.sv
module icache #(
    parameter int INDEX_W = icache_pkg::index_w_default
) (
    input  logic                            clk,
    input  logic                            rst,
    // fetch side
    input  logic                            valid,
    input  logic [icache_pkg::tag_w-1:0]    tag,
    input  logic [INDEX_W-1:0]              index,
    input  logic [icache_pkg::offset_w-1:0] offset,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic [icache_pkg::word_w-1:0]   rdata,
    // refill port
    output logic                            rd_req,
    output logic [icache_pkg::addr_w-1:0]   rd_addr,
    input  logic [icache_pkg::line_w-1:0]   ret_data
);
    import icache_pkg::*;

    logic                   hit;
    logic [word_w-1:0]      hit_word;
    logic                   victim_way;
    logic                   ram_rd;
    logic [INDEX_W-1:0]     ram_addr;
    logic [tag_w-1:0]       req_tag;
    logic                   word_sel;
    logic [ways-1:0]        way_we;
    logic [tag_w-1:0]       wtag;
    logic [line_w-1:0]      wblock;
    logic [ways*tag_w-1:0]  tags;
    logic [ways-1:0]        valids;
    logic [ways*line_w-1:0] blocks;

    icache_ctrl #(
        .INDEX_W(INDEX_W)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .valid      (valid),
        .tag        (tag),
        .index      (index),
        .offset     (offset),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .ret_data   (ret_data),
        .hit        (hit),
        .hit_word   (hit_word),
        .victim_way (victim_way),
        .ram_rd     (ram_rd),
        .ram_addr   (ram_addr),
        .req_tag    (req_tag),
        .word_sel   (word_sel),
        .way_we     (way_we),
        .wtag       (wtag),
        .wblock     (wblock)
    );

    icache_tag_store #(
        .INDEX_W(INDEX_W)
    ) u_tag_store (
        .clk    (clk),
        .rst    (rst),
        .rd     (ram_rd),
        .addr   (ram_addr),
        .we     (way_we),
        .wtag   (wtag),
        .tags   (tags),
        .valids (valids)
    );

    icache_data_ram #(
        .INDEX_W(INDEX_W)
    ) u_data_ram (
        .clk   (clk),
        .rd    (ram_rd),
        .addr  (ram_addr),
        .we    (way_we),
        .wdata (wblock),
        .rdata (blocks)
    );

    icache_way_select u_way_select (
        .clk        (clk),
        .rst        (rst),
        .req_tag    (req_tag),
        .word_sel   (word_sel),
        .tags       (tags),
        .valids     (valids),
        .blocks     (blocks),
        .hit        (hit),
        .hit_word   (hit_word),
        .victim_way (victim_way)
    );

endmodule

//--- source/icache_ctrl.sv
module icache_ctrl #(
    parameter int INDEX_W = icache_pkg::index_w_default
) (
    input  logic                            clk,
    input  logic                            rst,
    // fetch side
    input  logic                            valid,
    input  logic [icache_pkg::tag_w-1:0]    tag,
    input  logic [INDEX_W-1:0]              index,
    input  logic [icache_pkg::offset_w-1:0] offset,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic [icache_pkg::word_w-1:0]   rdata,
    // refill port
    output logic                            rd_req,
    output logic [icache_pkg::addr_w-1:0]   rd_addr,
    input  logic [icache_pkg::line_w-1:0]   ret_data,
    // from way select
    input  logic                            hit,
    input  logic [icache_pkg::word_w-1:0]   hit_word,
    input  logic                            victim_way,
    // to the arrays and way select
    output logic                            ram_rd,
    output logic [INDEX_W-1:0]              ram_addr,
    output logic [icache_pkg::tag_w-1:0]    req_tag,
    output logic                            word_sel,
    output logic [icache_pkg::ways-1:0]     way_we,
    output logic [icache_pkg::tag_w-1:0]    wtag,
    output logic [icache_pkg::line_w-1:0]   wblock
);
    import icache_pkg::*;

    cache_state_t state;
    cache_state_t next_state;

    logic               accept;
    logic [INDEX_W-1:0] req_index;
    logic [line_w-1:0]  miss_block;
    logic               miss_way;

    // a hitting lookup can take the next request
    assign addr_ok = (state == IDLE) || (state == LOOKUP && hit);
    assign accept  = valid && addr_ok;

    always_comb begin
        next_state = state;
        unique case (state)
            IDLE: begin
                if (accept) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    next_state = MISS;
                end else if (!valid) begin
                    next_state = IDLE;
                end
            end
            MISS: begin
                next_state = REPLACE;
            end
            REPLACE: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag   <= tag;
            req_index <= index;
            word_sel  <= offset[word_bit];
        end
    end

    // miss buffer
    // victim is latched because the toggle keeps moving
    always_ff @(posedge clk) begin
        if (state == MISS) begin
            miss_block <= ret_data;
            miss_way   <= victim_way;
        end
    end

    // memory answers in the strobe cycle
    assign rd_req  = (state == MISS);
    assign rd_addr = addr_w'({req_tag, req_index, offset_w'(0)});

    // array access
    assign ram_rd   = accept;
    assign ram_addr = (state == REPLACE) ? req_index : index;
    assign way_we   = (state == REPLACE) ? (ways'(1) << miss_way) : '0;
    assign wtag     = req_tag;
    assign wblock   = miss_block;

    // responses
    assign data_ok = (state == LOOKUP && hit) || (state == REPLACE);
    assign rdata   = (state == REPLACE) ? miss_block[word_sel*word_w +: word_w] : hit_word;

    // refill data has to be present together with the strobe
    a_ret_data_known: assert property (@(posedge clk) disable iff (rst)
        rd_req |-> !$isunknown(ret_data))
        else $error("refill data unknown in the strobe cycle");

endmodule

//--- source/icache_data_ram.sv
module icache_data_ram #(
    parameter int INDEX_W = icache_pkg::index_w_default
) (
    input  logic                                           clk,
    input  logic                                           rd,
    input  logic [INDEX_W-1:0]                             addr,
    input  logic [icache_pkg::ways-1:0]                    we,
    input  logic [icache_pkg::line_w-1:0]                  wdata,
    output logic [icache_pkg::ways*icache_pkg::line_w-1:0] rdata
);
    import icache_pkg::*;

    localparam int depth = 2 ** INDEX_W;

    // one block per way, same set addressed for both
    logic [line_w-1:0] mem [ways][depth];

    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (we[w]) begin
                mem[w][addr] <= wdata;
            end
        end
        // read register holds its value across writes
        if (rd) begin
            for (int w = 0; w < ways; w++) begin
                rdata[w*line_w +: line_w] <= mem[w][addr];
            end
        end
    end

    // the macro is single ported
    a_no_rd_wr_overlap: assert property (@(posedge clk) !(rd && (|we)))
        else $error("data ram read and write in the same cycle");

endmodule

//--- source/icache_pkg.sv
package icache_pkg;

    // refill address seen by the memory side
    localparam int unsigned addr_w = 32;

    // request address fields
    localparam int unsigned tag_w = 23;
    localparam int unsigned index_w_default = 6;
    localparam int unsigned offset_w = 3;

    // returned word and one way's block
    localparam int unsigned word_w = 32;
    localparam int unsigned line_w = 64;

    // associativity is fixed at two
    localparam int unsigned ways = 2;

    // offset bit that picks the word inside a line
    localparam int unsigned word_bit = $clog2(word_w / 8);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        LOOKUP  = 2'd1,
        MISS    = 2'd2,
        REPLACE = 2'd3
    } cache_state_t;

endpackage

//--- source/icache_tag_store.sv
module icache_tag_store #(
    parameter int INDEX_W = icache_pkg::index_w_default
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          rd,
    input  logic [INDEX_W-1:0]                            addr,
    input  logic [icache_pkg::ways-1:0]                   we,
    input  logic [icache_pkg::tag_w-1:0]                  wtag,
    output logic [icache_pkg::ways*icache_pkg::tag_w-1:0] tags,
    output logic [icache_pkg::ways-1:0]                   valids
);
    import icache_pkg::*;

    localparam int depth = 2 ** INDEX_W;

    logic [tag_w-1:0] tag_mem [ways][depth];

    // one valid vector per way, indexed by set
    logic [depth-1:0] valid_bits [ways];

    // tag arrays
    always_ff @(posedge clk) begin
        for (int w = 0; w < ways; w++) begin
            if (we[w]) begin
                tag_mem[w][addr] <= wtag;
            end
        end
        if (rd) begin
            for (int w = 0; w < ways; w++) begin
                tags[w*tag_w +: tag_w] <= tag_mem[w][addr];
            end
        end
    end

    // valid bits and their read register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < ways; w++) begin
                valid_bits[w] <= '0;
            end
            valids <= '0;
        end else begin
            for (int w = 0; w < ways; w++) begin
                if (we[w]) begin
                    valid_bits[w][addr] <= 1'b1;
                end
                if (rd) begin
                    valids[w] <= valid_bits[w][addr];
                end
            end
        end
    end

endmodule

//--- source/icache_way_select.sv
module icache_way_select (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic [icache_pkg::tag_w-1:0]                   req_tag,
    input  logic                                           word_sel,
    input  logic [icache_pkg::ways*icache_pkg::tag_w-1:0]  tags,
    input  logic [icache_pkg::ways-1:0]                    valids,
    input  logic [icache_pkg::ways*icache_pkg::line_w-1:0] blocks,
    output logic                                           hit,
    output logic [icache_pkg::word_w-1:0]                  hit_word,
    output logic                                           victim_way
);
    import icache_pkg::*;

    logic [ways-1:0] way_hit;
    logic            toggle;

    // tag compare per way
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            way_hit[w] = valids[w] && (tags[w*tag_w +: tag_w] == req_tag);
        end
    end

    assign hit = |way_hit;

    // word from the hitting way, zero when nothing hits
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < ways; w++) begin
            if (way_hit[w]) begin
                hit_word = hit_word | blocks[w*line_w + word_sel*word_w +: word_w];
            end
        end
    end

    // free-running pseudo-random bit
    always_ff @(posedge clk) begin
        if (rst) begin
            toggle <= 1'b0;
        end else begin
            toggle <= ~toggle;
        end
    end

    // invalid way first, lower number wins
    always_comb begin
        if (!valids[0]) begin
            victim_way = 1'b0;
        end else if (!valids[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = toggle;
        end
    end

    // a refill never duplicates a tag inside a set
    a_single_way_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
        else $error("both ways hit the same tag");

endmodule
